// ==== common/stepper_pkg.sv ====
package stepper_pkg;

  // counter and level widths
  localparam int phase_w = 8;
  localparam int off_w   = 10;
  localparam int tmr_w   = 8;
  localparam int lvl_w   = 8;

  // quadrant from the top two phase bits
  typedef enum logic [1:0] {
    q_pp = 2'b00,
    q_np = 2'b01,
    q_nn = 2'b10,
    q_pn = 2'b11
  } quadrant_t;

  // chopper state of one coil
  typedef enum logic [1:0] {
    dec_drive = 2'b00,
    dec_fast  = 2'b01,
    dec_slow  = 2'b10
  } decay_t;

  // rounded quarter sine in 16 points from 0 to 90 degrees
  localparam logic [lvl_w-1:0] sine_lut [16] = '{
    8'd0,
    8'd27,
    8'd53,
    8'd79,
    8'd104,
    8'd128,
    8'd150,
    8'd171,
    8'd190,
    8'd206,
    8'd221,
    8'd233,
    8'd243,
    8'd249,
    8'd254,
    8'd255
  };

endpackage

// ==== chopper/chopper_timer.sv ====
module chopper_timer (
  input  logic                          clk,
  input  logic                          resetn,
  input  logic                          bridge_start,
  input  logic                          off_start,
  input  logic [stepper_pkg::tmr_w-1:0] blank_len,
  input  logic [stepper_pkg::off_w-1:0] off_len,
  input  logic [stepper_pkg::tmr_w-1:0] min_on_len,
  output logic [stepper_pkg::tmr_w-1:0] blank_timer,
  output logic [stepper_pkg::off_w-1:0] off_timer,
  output logic [stepper_pkg::tmr_w-1:0] min_on_timer
);

  logic blank_run;
  logic off_run;
  logic min_on_run;

  assign blank_run  = (blank_timer != '0);
  assign off_run    = (off_timer != '0);
  assign min_on_run = (min_on_timer != '0);

  // blanking hides the turn-on spike from the comparator
  always_ff @(posedge clk) begin
    if (!resetn) begin
      blank_timer <= '0;
    end else if (bridge_start) begin
      blank_timer <= blank_len;
    end else if (blank_run) begin
      blank_timer <= blank_timer - stepper_pkg::tmr_w'(1);
    end
  end

  // off time that the control block splits into fast and slow decay
  always_ff @(posedge clk) begin
    if (!resetn) begin
      off_timer <= '0;
    end else if (off_start) begin
      off_timer <= off_len;
    end else if (off_run) begin
      off_timer <= off_timer - stepper_pkg::off_w'(1);
    end
  end

  // minimum on time shares the bridge start strobe with blanking
  always_ff @(posedge clk) begin
    if (!resetn) begin
      min_on_timer <= '0;
    end else if (bridge_start) begin
      min_on_timer <= min_on_len;
    end else if (min_on_run) begin
      min_on_timer <= min_on_timer - stepper_pkg::tmr_w'(1);
    end
  end

endmodule

// ==== hw/commutation_table.sv ====
module commutation_table (
  input  logic [stepper_pkg::phase_w-1:0] phase_ct,
  output logic                            s1,
  output logic                            s2,
  output logic                            s3,
  output logic                            s4,
  output logic [stepper_pkg::lvl_w-1:0]   vref_a,
  output logic [stepper_pkg::lvl_w-1:0]   vref_b
);

  stepper_pkg::quadrant_t quadrant;
  logic [3:0]             idx;
  logic [3:0]             idx_mirror;
  logic                   a_fwd;
  logic                   b_fwd;

  assign quadrant   = stepper_pkg::quadrant_t'(phase_ct[stepper_pkg::phase_w-1 -: 2]);
  assign idx        = phase_ct[stepper_pkg::phase_w-3 -: 4];
  assign idx_mirror = 4'd15 - idx;

  always_comb begin
    case (quadrant)
      stepper_pkg::q_pp: begin
        a_fwd = 1'b1;
        b_fwd = 1'b1;
      end
      stepper_pkg::q_np: begin
        a_fwd = 1'b0;
        b_fwd = 1'b1;
      end
      stepper_pkg::q_nn: begin
        a_fwd = 1'b0;
        b_fwd = 1'b0;
      end
      default: begin
        a_fwd = 1'b1;
        b_fwd = 1'b0;
      end
    endcase
  end

  // forward leg and its complement for each coil
  assign s1 = a_fwd;
  assign s2 = ~a_fwd;
  assign s3 = b_fwd;
  assign s4 = ~b_fwd;

  // coil A follows the cosine, coil B the sine
  assign vref_a = stepper_pkg::sine_lut[idx_mirror];
  assign vref_b = stepper_pkg::sine_lut[idx];

endmodule

// ==== hw/microstepper_control.sv ====
module microstepper_control (
  input  logic                            clk,
  input  logic                            resetn,
  input  logic                            step,
  input  logic                            dir,
  input  logic                            enable,
  input  logic                            analog_cmp_a,
  input  logic                            analog_cmp_b,
  input  logic [stepper_pkg::off_w-1:0]   fastdecay_threshold,
  input  logic                            invert_highside,
  input  logic                            invert_lowside,
  input  logic                            s1,
  input  logic                            s2,
  input  logic                            s3,
  input  logic                            s4,
  input  logic [stepper_pkg::tmr_w-1:0]   blank_timer_a,
  input  logic [stepper_pkg::tmr_w-1:0]   blank_timer_b,
  input  logic [stepper_pkg::off_w-1:0]   off_timer_a,
  input  logic [stepper_pkg::off_w-1:0]   off_timer_b,
  input  logic [stepper_pkg::tmr_w-1:0]   min_on_timer_a,
  input  logic [stepper_pkg::tmr_w-1:0]   min_on_timer_b,
  output logic [3:0]                      s_h,
  output logic [3:0]                      s_l,
  output logic                            fault,
  output logic [stepper_pkg::phase_w-1:0] phase_ct,
  output logic                            off_start_a,
  output logic                            off_start_b,
  output logic                            bridge_start_a,
  output logic                            bridge_start_b
);

  logic [2:0] step_sync;
  logic [1:0] dir_sync;
  logic       step_rise;

  // two-deep polarity history in leg order A1 A2 B1 B2
  logic [3:0] pol_d0;
  logic [3:0] pol_d1;
  logic [3:0] leg_falling;

  stepper_pkg::decay_t decay_a;
  stepper_pkg::decay_t decay_b;
  logic                fault_a;
  logic                fault_b;
  logic                block;

  // off timer zero means drive, high values fast decay, the rest slow
  function automatic stepper_pkg::decay_t classify(
    input logic [stepper_pkg::off_w-1:0] off_t,
    input logic [stepper_pkg::off_w-1:0] thr
  );
    if (off_t == '0) begin
      return stepper_pkg::dec_drive;
    end else if (off_t >= thr) begin
      return stepper_pkg::dec_fast;
    end else begin
      return stepper_pkg::dec_slow;
    end
  endfunction

  // bits 2:1 of the shift are the synchronized history
  assign step_rise = (step_sync[2:1] == 2'b01);

  always_ff @(posedge clk) begin
    if (!resetn) begin
      step_sync <= '0;
      dir_sync  <= '0;
      phase_ct  <= '0;
    end else begin
      step_sync <= {step_sync[1:0], step};
      dir_sync  <= {dir_sync[0], dir};
      if (step_rise) begin
        if (dir_sync[1]) begin
          phase_ct <= phase_ct + stepper_pkg::phase_w'(1);
        end else begin
          phase_ct <= phase_ct - stepper_pkg::phase_w'(1);
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!resetn) begin
      pol_d0 <= '0;
      pol_d1 <= '0;
    end else begin
      pol_d0 <= {s4, s3, s2, s1};
      pol_d1 <= pol_d0;
    end
  end

  // a leg that just went 1 to 0 starts a new on period
  assign leg_falling    = pol_d1 & ~pol_d0;
  assign bridge_start_a = |leg_falling[1:0];
  assign bridge_start_b = |leg_falling[3:2];

  // peak reached outside blanking and no off time running
  assign off_start_a = analog_cmp_a && (blank_timer_a == '0) && (off_timer_a == '0);
  assign off_start_b = analog_cmp_b && (blank_timer_b == '0) && (off_timer_b == '0);

  assign decay_a = classify(off_timer_a, fastdecay_threshold);
  assign decay_b = classify(off_timer_b, fastdecay_threshold);

  // off time requested before the minimum on time ran out
  assign fault_a = (min_on_timer_a != '0) && (off_timer_a != '0);
  assign fault_b = (min_on_timer_b != '0) && (off_timer_b != '0);
  assign fault   = fault_a | fault_b;
  assign block   = fault | ~enable;

  for (genvar i = 0; i < 4; i++) begin : g_leg
    stepper_pkg::decay_t mode;
    logic                req_h;
    logic                req_l;

    assign mode = (i < 2) ? decay_a : decay_b;

    always_comb begin
      case (mode)
        stepper_pkg::dec_fast: begin
          req_h = ~pol_d1[i];
          req_l = pol_d1[i];
        end
        stepper_pkg::dec_slow: begin
          req_h = 1'b0;
          req_l = 1'b1;
        end
        default: begin
          req_h = pol_d1[i];
          req_l = ~pol_d1[i];
        end
      endcase
    end

    // gates are active low, so a blocked leg reads 1
    assign s_h[i] = ~(req_h ^ invert_highside) | block;
    assign s_l[i] = ~(req_l ^ invert_lowside) | block;
  end

endmodule

// ==== hw/microstepper_top.sv ====
module microstepper_top (
  input  logic                            clk,
  input  logic                            resetn,
  input  logic                            step,
  input  logic                            dir,
  input  logic                            enable,
  input  logic                            analog_cmp_a,
  input  logic                            analog_cmp_b,
  input  logic [stepper_pkg::off_w-1:0]   fastdecay_threshold,
  input  logic                            invert_highside,
  input  logic                            invert_lowside,
  input  logic [stepper_pkg::tmr_w-1:0]   blank_len,
  input  logic [stepper_pkg::off_w-1:0]   off_len,
  input  logic [stepper_pkg::tmr_w-1:0]   min_on_len,
  output logic [3:0]                      s_h,
  output logic [3:0]                      s_l,
  output logic                            fault,
  output logic [stepper_pkg::phase_w-1:0] phase_ct,
  output logic [stepper_pkg::lvl_w-1:0]   vref_a,
  output logic [stepper_pkg::lvl_w-1:0]   vref_b
);

  logic                          s1;
  logic                          s2;
  logic                          s3;
  logic                          s4;
  logic                          off_start_a;
  logic                          off_start_b;
  logic                          bridge_start_a;
  logic                          bridge_start_b;
  logic [stepper_pkg::tmr_w-1:0] blank_timer_a;
  logic [stepper_pkg::tmr_w-1:0] blank_timer_b;
  logic [stepper_pkg::off_w-1:0] off_timer_a;
  logic [stepper_pkg::off_w-1:0] off_timer_b;
  logic [stepper_pkg::tmr_w-1:0] min_on_timer_a;
  logic [stepper_pkg::tmr_w-1:0] min_on_timer_b;

  microstepper_control microstepper_control_inst (
    .clk                 (clk),
    .resetn              (resetn),
    .step                (step),
    .dir                 (dir),
    .enable              (enable),
    .analog_cmp_a        (analog_cmp_a),
    .analog_cmp_b        (analog_cmp_b),
    .fastdecay_threshold (fastdecay_threshold),
    .invert_highside     (invert_highside),
    .invert_lowside      (invert_lowside),
    .s1                  (s1),
    .s2                  (s2),
    .s3                  (s3),
    .s4                  (s4),
    .blank_timer_a       (blank_timer_a),
    .blank_timer_b       (blank_timer_b),
    .off_timer_a         (off_timer_a),
    .off_timer_b         (off_timer_b),
    .min_on_timer_a      (min_on_timer_a),
    .min_on_timer_b      (min_on_timer_b),
    .s_h                 (s_h),
    .s_l                 (s_l),
    .fault               (fault),
    .phase_ct            (phase_ct),
    .off_start_a         (off_start_a),
    .off_start_b         (off_start_b),
    .bridge_start_a      (bridge_start_a),
    .bridge_start_b      (bridge_start_b)
  );

  commutation_table commutation_table_inst (
    .phase_ct (phase_ct),
    .s1       (s1),
    .s2       (s2),
    .s3       (s3),
    .s4       (s4),
    .vref_a   (vref_a),
    .vref_b   (vref_b)
  );

  // one chopper per coil
  chopper_timer chopper_a (
    .clk          (clk),
    .resetn       (resetn),
    .bridge_start (bridge_start_a),
    .off_start    (off_start_a),
    .blank_len    (blank_len),
    .off_len      (off_len),
    .min_on_len   (min_on_len),
    .blank_timer  (blank_timer_a),
    .off_timer    (off_timer_a),
    .min_on_timer (min_on_timer_a)
  );

  chopper_timer chopper_b (
    .clk          (clk),
    .resetn       (resetn),
    .bridge_start (bridge_start_b),
    .off_start    (off_start_b),
    .blank_len    (blank_len),
    .off_len      (off_len),
    .min_on_len   (min_on_len),
    .blank_timer  (blank_timer_b),
    .off_timer    (off_timer_b),
    .min_on_timer (min_on_timer_b)
  );

endmodule

// ==== tb/microstepper_vectors.svh ====
`ifndef MICROSTEPPER_VECTORS_SVH
`define MICROSTEPPER_VECTORS_SVH

typedef struct packed {
  logic [stepper_pkg::off_w-1:0]   thr;
  logic                            inv_h;
  logic                            inv_l;
  logic [stepper_pkg::tmr_w-1:0]   blank;
  logic [stepper_pkg::off_w-1:0]   off;
  logic [stepper_pkg::tmr_w-1:0]   min_on;
  logic [stepper_pkg::tmr_w-1:0]   pulse;
  logic [stepper_pkg::phase_w-1:0] steps;
  logic                            dir;
} vec_t;

localparam int num_vecs = 8;

// column order is threshold inv_h inv_l blank off min_on pulse steps dir
// steps and dir are drawn at run time
vec_t vecs [num_vecs] = '{
  '{10'd20, 1'b0, 1'b0, 8'd10, 10'd40, 8'd8,  8'd14, 8'd0, 1'b0},
  '{10'd20, 1'b0, 1'b0, 8'd10, 10'd40, 8'd8,  8'd5,  8'd0, 1'b0},
  '{10'd16, 1'b0, 1'b0, 8'd6,  10'd48, 8'd30, 8'd12, 8'd0, 1'b0},
  '{10'd12, 1'b1, 1'b1, 8'd8,  10'd30, 8'd4,  8'd12, 8'd0, 1'b0},
  '{10'd24, 1'b1, 1'b0, 8'd12, 10'd50, 8'd12, 8'd6,  8'd0, 1'b0},
  '{10'd8,  1'b0, 1'b1, 8'd4,  10'd24, 8'd20, 8'd9,  8'd0, 1'b0},
  '{10'd30, 1'b0, 1'b0, 8'd16, 10'd64, 8'd10, 8'd20, 8'd0, 1'b0},
  '{10'd10, 1'b1, 1'b1, 8'd6,  10'd20, 8'd16, 8'd10, 8'd0, 1'b0}
};

function automatic logic [stepper_pkg::lvl_w-1:0] cos_level(
  input logic [stepper_pkg::phase_w-1:0] phase
);
  return stepper_pkg::sine_lut[4'd15 - phase[5:2]];
endfunction

function automatic logic [stepper_pkg::lvl_w-1:0] sin_level(
  input logic [stepper_pkg::phase_w-1:0] phase
);
  return stepper_pkg::sine_lut[phase[5:2]];
endfunction

// leg bits A1 A2 B1 B2 from bit 0 upward
function automatic logic [3:0] leg_polarity(input logic [stepper_pkg::phase_w-1:0] phase);
  case (stepper_pkg::quadrant_t'(phase[7:6]))
    stepper_pkg::q_pp: return 4'b0101;
    stepper_pkg::q_np: return 4'b0110;
    stepper_pkg::q_nn: return 4'b1010;
    default:           return 4'b1001;
  endcase
endfunction

// value read n cycles after the load strobe and zero before it
function automatic int timer_at(input int len, input int n);
  if (n < 1) begin
    return 0;
  end else if (len > n - 1) begin
    return len - (n - 1);
  end
  return 0;
endfunction

// the pulse only counts once blanking is over
function automatic int off_timer_at(input int n, input int p, input int blank, input int off);
  if (timer_at(blank, p) != 0) begin
    return 0;
  end
  return timer_at(off, n - p);
endfunction

function automatic stepper_pkg::decay_t decay_mode(input int off, input int thr);
  if (off == 0) begin
    return stepper_pkg::dec_drive;
  end else if (off >= thr) begin
    return stepper_pkg::dec_fast;
  end
  return stepper_pkg::dec_slow;
endfunction

// returns {s_l, s_h} as active low gates
function automatic logic [7:0] gate_model(
  input logic [3:0]          pol,
  input stepper_pkg::decay_t dec_a,
  input stepper_pkg::decay_t dec_b,
  input logic                inv_h,
  input logic                inv_l,
  input logic                block
);
  logic [3:0]          hs;
  logic [3:0]          ls;
  logic                want_h;
  logic                want_l;
  stepper_pkg::decay_t d;
  for (int i = 0; i < 4; i++) begin
    d = (i < 2) ? dec_a : dec_b;
    if (d == stepper_pkg::dec_slow) begin
      want_h = 1'b0;
      want_l = 1'b1;
    end else if (d == stepper_pkg::dec_fast) begin
      want_h = !pol[i];
      want_l = pol[i];
    end else begin
      want_h = pol[i];
      want_l = !pol[i];
    end
    if (inv_h) want_h = !want_h;
    if (inv_l) want_l = !want_l;
    hs[i] = block ? 1'b1 : !want_h;
    ls[i] = block ? 1'b1 : !want_l;
  end
  return {ls, hs};
endfunction

`endif

// ==== tb/microstepper_tb.sv ====
module microstepper_tb;

  `include "microstepper_vectors.svh"

  localparam int clk_period     = 40;
  localparam int cycles_per_vec = 200;

  logic                            clk;
  logic                            resetn;
  logic                            step;
  logic                            dir;
  logic                            enable;
  logic                            analog_cmp_a;
  logic                            analog_cmp_b;
  logic [stepper_pkg::off_w-1:0]   fastdecay_threshold;
  logic                            invert_highside;
  logic                            invert_lowside;
  logic [stepper_pkg::tmr_w-1:0]   blank_len;
  logic [stepper_pkg::off_w-1:0]   off_len;
  logic [stepper_pkg::tmr_w-1:0]   min_on_len;
  logic [3:0]                      s_h;
  logic [3:0]                      s_l;
  logic                            fault;
  logic [stepper_pkg::phase_w-1:0] phase_ct;
  logic [stepper_pkg::lvl_w-1:0]   vref_a;
  logic [stepper_pkg::lvl_w-1:0]   vref_b;

  logic                            monitor_on;
  logic [31:0]                     rng_state;
  logic [stepper_pkg::phase_w-1:0] exp_phase;

  microstepper_top microstepper_top_inst (
    .clk                 (clk),
    .resetn              (resetn),
    .step                (step),
    .dir                 (dir),
    .enable              (enable),
    .analog_cmp_a        (analog_cmp_a),
    .analog_cmp_b        (analog_cmp_b),
    .fastdecay_threshold (fastdecay_threshold),
    .invert_highside     (invert_highside),
    .invert_lowside      (invert_lowside),
    .blank_len           (blank_len),
    .off_len             (off_len),
    .min_on_len          (min_on_len),
    .s_h                 (s_h),
    .s_l                 (s_l),
    .fault               (fault),
    .phase_ct            (phase_ct),
    .vref_a              (vref_a),
    .vref_b              (vref_b)
  );

  initial begin
    clk = 1'b1;
    forever #(clk_period / 2) clk = ~clk;
  end

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("TEST FAILED");
    $fatal(1, "simulation stopped");
  endtask

  initial begin
    repeat (num_vecs * cycles_per_vec) @(posedge clk);
    abort_run("timeout: the test sequence did not finish in time");
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x ^= x << 13;
    x ^= x >> 17;
    x ^= x << 5;
    return x;
  endfunction

  task automatic check_phase(input string name, input logic [stepper_pkg::phase_w-1:0] got,
                             input logic [stepper_pkg::phase_w-1:0] exp);
    if (got !== exp) abort_run($sformatf("** Error: %s got %h expected %h", name, got, exp));
  endtask

  task automatic check_level(input string name, input logic [stepper_pkg::lvl_w-1:0] got,
                             input logic [stepper_pkg::lvl_w-1:0] exp);
    if (got !== exp) abort_run($sformatf("** Error: %s got %h expected %h", name, got, exp));
  endtask

  task automatic check_gates(input string name, input logic [3:0] got, input logic [3:0] exp);
    if (got !== exp) abort_run($sformatf("** Error: %s got %h expected %h", name, got, exp));
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) abort_run($sformatf("** Error: %s got %h expected %h", name, got, exp));
  endtask

  task automatic check_decay(input string name, input stepper_pkg::decay_t got,
                             input stepper_pkg::decay_t exp);
    if (got !== exp) abort_run($sformatf("** Error: %s got %h expected %h", name, got, exp));
  endtask

  // read coil B's chopper state back from its two legs
  function automatic stepper_pkg::decay_t decode_decay(input logic [3:0] gh, input logic [3:0] gl,
                                                       input logic ih, input logic il,
                                                       input logic [3:0] pol);
    logic [1:0] req_h;
    logic [1:0] req_l;
    req_h = ~gh[3:2] ^ {2{ih}};
    req_l = ~gl[3:2] ^ {2{il}};
    if (req_h == 2'b00 && req_l == 2'b11) begin
      return stepper_pkg::dec_slow;
    end else if (req_h == pol[3:2]) begin
      return stepper_pkg::dec_drive;
    end
    return stepper_pkg::dec_fast;
  endfunction

  // no leg may have both switches on
  always @(posedge clk) begin
    if (monitor_on && resetn) begin
      for (int i = 0; i < 4; i++) begin
        if (!s_h[i] && !s_l[i]) begin
          abort_run($sformatf("** Error: shoot-through on leg %0d s_h %h s_l %h", i, s_h, s_l));
        end
      end
    end
  end

  task automatic fill_random_steps();
    for (int i = 0; i < num_vecs; i++) begin
      rng_state = xorshift32(rng_state);
      vecs[i].steps = 8'(4 + rng_state % 12);
      rng_state = xorshift32(rng_state);
      vecs[i].dir = rng_state[7];
    end
  endtask

  task automatic apply_reset(input vec_t v);
    @(negedge clk);
    monitor_on          = 1'b0;
    resetn              = 1'b0;
    step                = 1'b0;
    dir                 = 1'b0;
    enable              = 1'b1;
    analog_cmp_a        = 1'b0;
    analog_cmp_b        = 1'b0;
    fastdecay_threshold = v.thr;
    invert_highside     = v.inv_h;
    invert_lowside      = v.inv_l;
    blank_len           = v.blank;
    off_len             = v.off;
    min_on_len          = v.min_on;
    repeat (2) @(negedge clk);
    resetn     = 1'b1;
    monitor_on = !v.inv_h && !v.inv_l;
  endtask

  task automatic check_levels(input logic [stepper_pkg::phase_w-1:0] phase);
    check_level("vref_a", vref_a, cos_level(phase));
    check_level("vref_b", vref_b, sin_level(phase));
  endtask

  task automatic check_drive_gates(input logic [stepper_pkg::phase_w-1:0] phase, input vec_t v);
    logic [7:0] exp_g;
    exp_g = gate_model(leg_polarity(phase), stepper_pkg::dec_drive, stepper_pkg::dec_drive,
                       v.inv_h, v.inv_l, 1'b0);
    check_flag("fault", fault, 1'b0);
    check_gates("s_h", s_h, exp_g[3:0]);
    check_gates("s_l", s_l, exp_g[7:4]);
  endtask

  task automatic check_reset_state(input vec_t v);
    // polarity history needs two edges to fill
    repeat (3) @(negedge clk);
    exp_phase = '0;
    check_phase("phase_ct", phase_ct, exp_phase);
    check_levels(exp_phase);
    check_drive_gates(exp_phase, v);
    enable = 1'b0;
    @(negedge clk);
    check_gates("s_h", s_h, 4'hf);
    check_gates("s_l", s_l, 4'hf);
    enable = 1'b1;
    @(negedge clk);
  endtask

  task automatic check_chopper_state(input vec_t v, input int n);
    int                  off_now;
    logic                flt;
    stepper_pkg::decay_t dec;
    logic [7:0]          exp_g;
    off_now = off_timer_at(n, int'(v.pulse), int'(v.blank), int'(v.off));
    flt     = (timer_at(int'(v.min_on), n) != 0) && (off_now != 0);
    dec     = decay_mode(off_now, int'(v.thr));
    exp_g   = gate_model(leg_polarity(8'hff), stepper_pkg::dec_drive, dec,
                         v.inv_h, v.inv_l, flt);
    check_flag("fault", fault, flt);
    if (!flt) begin
      check_decay("coil b decay", decode_decay(s_h, s_l, v.inv_h, v.inv_l, leg_polarity(8'hff)),
                  dec);
    end
    check_gates("s_h", s_h, exp_g[3:0]);
    check_gates("s_l", s_l, exp_g[7:4]);
  endtask

  // one step down from 0 enters q_pn, B1 falls and coil B gets a bridge start
  task automatic run_chopper(input vec_t v);
    int p;
    int n;
    int n_fast;
    int n_slow;
    int n_drive;
    int n_fault;
    int n_clear;
    int n_end;
    p       = int'(v.pulse);
    n_fast  = p + 1 + (int'(v.off) - int'(v.thr)) / 2;
    n_slow  = p + 1 + int'(v.off) - int'(v.thr) / 2;
    n_drive = p + 1 + int'(v.off) + 3;
    n_fault = (p + 1 + int'(v.min_on)) / 2;
    n_clear = int'(v.min_on) + 3;
    n_end   = (n_drive > n_clear) ? n_drive : n_clear;
    step = 1'b1;
    for (int k = 1; k <= n_end + 4; k++) begin
      @(negedge clk);
      n = k - 4;
      if (k == 3) begin
        check_phase("phase_ct", phase_ct, 8'hff);
        check_levels(8'hff);
        step = 1'b0;
      end
      if (n == 1 || n == n_fast || n == n_slow || n == n_drive || n == n_fault ||
          n == n_clear) begin
        check_chopper_state(v, n);
      end
      analog_cmp_b = (n == p);
    end
    analog_cmp_b = 1'b0;
    exp_phase    = 8'hff;
  endtask

  task automatic run_burst(input vec_t v);
    dir = v.dir;
    repeat (3) @(negedge clk);
    for (int i = 0; i < int'(v.steps); i++) begin
      step = 1'b1;
      repeat (3) @(negedge clk);
      if (v.dir) begin
        exp_phase = exp_phase + 8'd1;
      end else begin
        exp_phase = exp_phase - 8'd1;
      end
      check_phase("phase_ct", phase_ct, exp_phase);
      check_levels(exp_phase);
      step = 1'b0;
      // gates follow the phase two cycles later
      repeat (2) @(negedge clk);
      check_drive_gates(exp_phase, v);
      @(negedge clk);
    end
  endtask

  initial begin
    resetn              = 1'b0;
    step                = 1'b0;
    dir                 = 1'b0;
    enable              = 1'b1;
    analog_cmp_a        = 1'b0;
    analog_cmp_b        = 1'b0;
    fastdecay_threshold = '0;
    invert_highside     = 1'b0;
    invert_lowside      = 1'b0;
    blank_len           = '0;
    off_len             = '0;
    min_on_len          = '0;
    monitor_on          = 1'b0;
    exp_phase           = '0;
    rng_state           = 32'h2948;
    fill_random_steps();
    for (int e = 0; e < num_vecs; e++) begin
      apply_reset(vecs[e]);
      check_reset_state(vecs[e]);
      run_chopper(vecs[e]);
      run_burst(vecs[e]);
    end
    $display("TEST OK");
    $finish;
  end

endmodule

// ==== verilog.f ====
+incdir+tb
common/stepper_pkg.sv
chopper/chopper_timer.sv
hw/commutation_table.sv
hw/microstepper_control.sv
hw/microstepper_top.sv
tb/microstepper_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing -f verilog.f --top-module microstepper_tb -o microstepper_sim

sim_out=$(./obj_dir/microstepper_sim 2>&1) || true
echo "$sim_out"

if grep -qx "TEST OK" <<< "$sim_out"; then
  exit 0
else
  exit 1
fi
